// File: logic/board_pkg.sv
package board_pkg;

    localparam int clk_mhz = 25;             // board oscillator

    localparam int w_key   = 4;
    localparam int w_led   = 4;
    localparam int w_color = 4;              // bits per vga colour channel

    // key roles, the last key is reserved for reset
    localparam int key_run  = 0;             // toggles run and pause
    localparam int key_dir  = 1;             // reverses direction
    localparam int key_mode = 2;             // counter or rotate pattern
    localparam int key_rst  = 3;

    localparam int w_lab_key = 3;            // keys seen by the lab core

endpackage

// File: logic/video_pkg.sv
package video_pkg;

    localparam int w_x = 10;                 // horizontal counter width
    localparam int w_y = 10;                 // vertical counter width

    // 640x480 at 60 Hz, horizontal values in pixels
    localparam logic [w_x - 1:0] h_visible = 640;
    localparam logic [w_x - 1:0] h_front   = 16;
    localparam logic [w_x - 1:0] h_sync    = 96;
    localparam logic [w_x - 1:0] h_back    = 48;
    localparam logic [w_x - 1:0] h_total   = h_visible + h_front + h_sync + h_back;

    // vertical values in lines
    localparam logic [w_y - 1:0] v_visible = 480;
    localparam logic [w_y - 1:0] v_front   = 10;
    localparam logic [w_y - 1:0] v_sync    = 2;
    localparam logic [w_y - 1:0] v_back    = 33;
    localparam logic [w_y - 1:0] v_total   = v_visible + v_front + v_sync + v_back;

    localparam logic [w_x - 1:0] stripe_width = 80;  // eight bands across the screen

endpackage

// File: logic/vga_if.sv
`timescale 1ns/1ns

interface vga_if;

    logic [video_pkg::w_x - 1:0] x;          // raster column
    logic [video_pkg::w_y - 1:0] y;          // raster line
    logic                        hsync;      // active low
    logic                        vsync;      // active low
    logic                        visible;    // inside the 640x480 area

    modport timing
    (
        output x,
        output y,
        output hsync,
        output vsync,
        output visible
    );

    modport pixel
    (
        input x,
        input y,
        input hsync,
        input vsync,
        input visible
    );

endinterface

// File: logic/slow_clk_gen.sv
`timescale 1ns/1ns

module slow_clk_gen
#(
    parameter int slow_hz = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_tick
);

    localparam int ratio = board_pkg::clk_mhz * 1000000 / slow_hz;  // clk cycles per tick
    localparam int w_cnt = $clog2(ratio + 1);

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt       <= w_cnt'(ratio - 1);
            slow_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt       <= w_cnt'(ratio - 1);  // reload on terminal count
            slow_tick <= 1'b1;
        end
        else
        begin
            cnt       <= cnt - 1'b1;
            slow_tick <= 1'b0;
        end
    end

endmodule

// File: logic/key_debouncer.sv
`timescale 1ns/1ns

module key_debouncer
#(
    parameter int debounce_cycles = 250000
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [board_pkg::w_lab_key - 1:0] key,
    output logic [board_pkg::w_lab_key - 1:0] press
);

    localparam int w_cnt = $clog2(debounce_cycles + 1);

    // each key gets its own synchroniser, stability counter and accepted level
    for (genvar i = 0; i < board_pkg::w_lab_key; i++)
    begin : g_key
        logic [1:0]         sync_q;          // two-flop synchroniser
        logic               level;           // accepted, debounced level
        logic [w_cnt - 1:0] cnt;

        always_ff @(posedge clk)
        begin
            if (rst)
                sync_q <= 2'b00;
            else
                sync_q <= {sync_q[0], key[i]};
        end

        always_ff @(posedge clk)
        begin
            if (rst)
            begin
                level    <= 1'b0;
                cnt      <= '0;
                press[i] <= 1'b0;
            end
            else if (sync_q[1] == level)
            begin
                cnt      <= '0;              // bounce back, start over
                press[i] <= 1'b0;
            end
            else if (cnt == w_cnt'(debounce_cycles - 1))
            begin
                // new level held long enough, commit it
                level    <= sync_q[1];
                cnt      <= '0;
                press[i] <= sync_q[1];       // only a rising commit is a press
            end
            else
            begin
                cnt      <= cnt + 1'b1;
                press[i] <= 1'b0;
            end
        end
    end

endmodule

// File: logic/led_pattern.sv
`timescale 1ns/1ns

module led_pattern
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              slow_tick,
    input  logic [board_pkg::w_lab_key - 1:0] press,
    output logic [board_pkg::w_led - 1:0]     led
);

    logic running;                           // cleared while paused
    logic dir_down;                          // 0 counts up or rotates left
    logic rotate_mode;                       // 0 binary counter, 1 walking bit

    logic [board_pkg::w_led - 1:0] next_led;

    // value for the next slow tick
    always_comb
    begin
        if (rotate_mode)
        begin
            if (dir_down)
                next_led = {led[0], led[board_pkg::w_led - 1:1]};
            else
                next_led = {led[board_pkg::w_led - 2:0], led[board_pkg::w_led - 1]};
        end
        else
        begin
            if (dir_down)
                next_led = led - 1'b1;       // wraps modulo 16
            else
                next_led = led + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running     <= 1'b1;
            dir_down    <= 1'b0;
            rotate_mode <= 1'b0;
            led         <= '0;
        end
        else if (|press)
        begin
            // a press wins over a coinciding tick
            if (press[board_pkg::key_run])
                running <= !running;

            if (press[board_pkg::key_dir])
                dir_down <= !dir_down;       // led value is left alone

            if (press[board_pkg::key_mode])
            begin
                rotate_mode <= !rotate_mode;
                led         <= rotate_mode ? '0 : board_pkg::w_led'(1);
            end
        end
        else if (slow_tick && running)
        begin
            led <= next_led;
        end
    end

endmodule

// File: logic/vga_timing.sv
`timescale 1ns/1ns

module vga_timing
(
    input  logic clk,
    input  logic rst,
    vga_if.timing raster
);

    logic [video_pkg::w_x - 1:0] h_cnt;
    logic [video_pkg::w_y - 1:0] v_cnt;

    logic h_last;                            // last pixel of a line
    logic v_last;                            // last line of a frame
    logic h_sync_zone;
    logic v_sync_zone;

    assign h_last = (h_cnt == video_pkg::h_total - 1'b1);
    assign v_last = (v_cnt == video_pkg::v_total - 1'b1);

    // sync pulses sit after the front porch
    assign h_sync_zone = (h_cnt >= video_pkg::h_visible + video_pkg::h_front)
                      && (h_cnt <  video_pkg::h_visible + video_pkg::h_front + video_pkg::h_sync);
    assign v_sync_zone = (v_cnt >= video_pkg::v_visible + video_pkg::v_front)
                      && (v_cnt <  video_pkg::v_visible + video_pkg::v_front + video_pkg::v_sync);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // position is registered too so it stays aligned with the flags
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            raster.x       <= '0;
            raster.y       <= '0;
            raster.hsync   <= 1'b1;
            raster.vsync   <= 1'b1;
            raster.visible <= 1'b0;
        end
        else
        begin
            raster.x       <= h_cnt;
            raster.y       <= v_cnt;
            raster.hsync   <= !h_sync_zone;
            raster.vsync   <= !v_sync_zone;
            raster.visible <= (h_cnt < video_pkg::h_visible) && (v_cnt < video_pkg::v_visible);
        end
    end

endmodule

// File: logic/vga_stripes.sv
`timescale 1ns/1ns

module vga_stripes
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [board_pkg::w_led - 1:0]   led,
    vga_if.pixel                            raster,
    output logic                            hsync,
    output logic                            vsync,
    output logic [board_pkg::w_color - 1:0] red,
    output logic [board_pkg::w_color - 1:0] green,
    output logic [board_pkg::w_color - 1:0] blue
);

    logic [video_pkg::w_x - 1:0] band;       // 0 to 7 across the visible width
    logic [2:0]                  index;      // rgb select

    always_comb
    begin
        band  = raster.x / video_pkg::stripe_width;
        index = band[2:0] ^ led[2:0];        // pattern shuffles the bands
    end

    // colours and syncs leave on the same edge
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else
        begin
            hsync <= raster.hsync;
            vsync <= raster.vsync;
            red   <= (raster.visible && index[2]) ? '1 : '0;
            green <= (raster.visible && index[1]) ? '1 : '0;
            blue  <= (raster.visible && index[0]) ? '1 : '0;
        end
    end

endmodule

// File: logic/lab_top.sv
`timescale 1ns/1ns

module lab_top
#(
    parameter int debounce_cycles = 250000
)
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              slow_tick,
    input  logic [board_pkg::w_lab_key - 1:0] key,
    output logic [board_pkg::w_led - 1:0]     led,
    output logic                              hsync,
    output logic                              vsync,
    output logic [board_pkg::w_color - 1:0]   red,
    output logic [board_pkg::w_color - 1:0]   green,
    output logic [board_pkg::w_color - 1:0]   blue
);

    logic [board_pkg::w_lab_key - 1:0] press;  // one-cycle press pulses

    vga_if raster ();

    key_debouncer #(.debounce_cycles (debounce_cycles)) i_key_debouncer
    (
        .clk   (clk),
        .rst   (rst),
        .key   (key),
        .press (press)
    );

    led_pattern i_led_pattern
    (
        .clk       (clk),
        .rst       (rst),
        .slow_tick (slow_tick),
        .press     (press),
        .led       (led)
    );

    vga_timing i_vga_timing
    (
        .clk    (clk),
        .rst    (rst),
        .raster (raster.timing)
    );

    vga_stripes i_vga_stripes
    (
        .clk    (clk),
        .rst    (rst),
        .led    (led),                       // stripe colours follow the leds
        .raster (raster.pixel),
        .hsync  (hsync),
        .vsync  (vsync),
        .red    (red),
        .green  (green),
        .blue   (blue)
    );

endmodule

// File: logic/board_specific_top.sv
`timescale 1ns/1ns

module board_specific_top
#(
    parameter int slow_hz         = 1,
    parameter int debounce_cycles = 250000
)
(
    input  logic                            CLK,
    input  logic [board_pkg::w_key - 1:0]   KEY,
    output logic [board_pkg::w_led - 1:0]   LED,
    output logic                            VGA_HS,
    output logic                            VGA_VS,
    output logic [board_pkg::w_color - 1:0] VGA_R,
    output logic [board_pkg::w_color - 1:0] VGA_G,
    output logic [board_pkg::w_color - 1:0] VGA_B
);

    wire clk = CLK;
    wire rst = KEY[board_pkg::key_rst];      // keys are active high, used as is

    logic                              slow_tick;
    logic [board_pkg::w_lab_key - 1:0] lab_key;

    assign lab_key = KEY[board_pkg::w_lab_key - 1:0];  // reset key stays out

    // enable tick in the clk domain instead of a second clock
    slow_clk_gen #(.slow_hz (slow_hz)) i_slow_clk_gen
    (
        .clk       (clk),
        .rst       (rst),
        .slow_tick (slow_tick)
    );

    lab_top #(.debounce_cycles (debounce_cycles)) i_lab_top
    (
        .clk       (clk),
        .rst       (rst),
        .slow_tick (slow_tick),
        .key       (lab_key),
        .led       (LED),
        .hsync     (VGA_HS),
        .vsync     (VGA_VS),
        .red       (VGA_R),
        .green     (VGA_G),
        .blue      (VGA_B)
    );

endmodule

// File: tests/board_sva.sv
`timescale 1ns/1ns

module board_sva
(
    input logic                              clk,
    input logic                              rst,
    input logic                              hsync,
    input logic                              vsync,
    input logic [board_pkg::w_lab_key - 1:0] press
);

    logic [7:0] hs_low_cnt;                  // low cycles of the current hsync pulse

    always_ff @(posedge clk)
    begin
        if (hsync)
            hs_low_cnt <= '0;
        else
            hs_low_cnt <= hs_low_cnt + 1'b1;
    end

    // both syncs idle high once reset has been seen
    a_sync_after_rst: assert property (@(posedge clk) rst |=> (hsync && vsync))
        else $error("syncs not high after reset");

    a_hsync_width: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> (hs_low_cnt == 8'd96))
        else $error("hsync low width is not 96 cycles");

    a_press_single: assert property (@(posedge clk) disable iff (rst)
        !(|(press & $past(press))))
        else $error("press pulse longer than one cycle");

endmodule

bind lab_top board_sva u_board_sva
(
    .clk   (clk),
    .rst   (rst),
    .hsync (hsync),
    .vsync (vsync),
    .press (press)
);

// File: tests/tb_board.sv
`timescale 1ns/1ns

module tb_board;

    logic       clk;
    logic [3:0] key;
    logic [3:0] led;
    logic       vga_hs;
    logic       vga_vs;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    int errors;
    int tests_run;
    int tests_failed;

    board_specific_top #(.slow_hz (1250000), .debounce_cycles (4)) dut
    (
        .CLK    (clk),
        .KEY    (key),
        .LED    (led),
        .VGA_HS (vga_hs),
        .VGA_VS (vga_vs),
        .VGA_R  (vga_r),
        .VGA_G  (vga_g),
        .VGA_B  (vga_b)
    );

    always #2 clk = ~clk;                    // 4 ns period

    // all driving and sampling happens 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic press_key(input int idx);
        key[idx] = 1'b1;
        repeat (12) step_cycle();
        key[idx] = 1'b0;
        repeat (12) step_cycle();
    endtask

    // the lit bit walks one place and wraps at the end, the counter wraps modulo 16
    function automatic logic [3:0] next_pattern(input logic [3:0] prev, input bit rot,
                                                input bit down);
        if (rot && down)
            return (prev == 4'b0001) ? 4'b1000 : prev >> 1;
        if (rot)
            return (prev == 4'b1000) ? 4'b0001 : prev << 1;
        if (down)
            return 4'((int'(prev) + 15) % 16);
        return 4'((int'(prev) + 1) % 16);
    endfunction

    function automatic logic sync_pin(input bit use_vs);
        return use_vs ? vga_vs : vga_hs;
    endfunction

    task automatic wait_led_change(output bit ok);
        logic [3:0] prev;
        prev = led;
        ok   = 1'b0;
        for (int n = 0; n < 100; n++)
        begin
            step_cycle();
            if (led != prev)
            begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok)
        begin
            $display("Timeout at %0t: LED did not change", $time);
            errors++;
        end
    endtask

    // follows n LED changes and compares each with the rule
    task automatic follow_changes(input int n, input bit rot, input bit down);
        logic [3:0] exp;
        bit         ok;
        exp = led;                           // start of the expected sequence
        for (int i = 0; i < n; i++)
        begin
            exp = next_pattern(exp, rot, down);
            wait_led_change(ok);
            if (!ok)
                break;
            if (led != exp)
                report_mismatch("LED", led, exp);
        end
    endtask

    // waits for a rising edge when level is 1 and a falling one when it is 0
    task automatic wait_sync_edge(input bit use_vs, input bit level, input int limit,
                                  output bit ok);
        bit seen_other;
        seen_other = 1'b0;
        ok         = 1'b0;
        for (int n = 0; n < limit; n++)
        begin
            step_cycle();
            if (sync_pin(use_vs) != level)
                seen_other = 1'b1;
            else if (seen_other)
            begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok)
        begin
            $display("Timeout at %0t: no %s edge on %s", $time,
                     level ? "rising" : "falling", use_vs ? "VGA_VS" : "VGA_HS");
            errors++;
        end
    endtask

    task automatic measure_sync(input bit use_vs, input int exp_low, input int exp_period,
                                input int limit);
        int period;
        int low;
        bit rose;
        bit ok;
        wait_sync_edge(use_vs, 1'b0, limit, ok);
        if (!ok)
            return;
        period = 0;
        low    = 1;
        rose   = 1'b0;
        ok     = 1'b0;
        for (int n = 0; n < limit; n++)
        begin
            step_cycle();
            period++;
            if (!rose)
            begin
                if (sync_pin(use_vs))
                    rose = 1'b1;
                else
                    low++;
            end
            else if (!sync_pin(use_vs))
            begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok)
        begin
            $display("Timeout at %0t: sync period never ended", $time);
            errors++;
        end
        else
        begin
            if (low != exp_low)
                report_mismatch(use_vs ? "VGA_VS low width" : "VGA_HS low width", low, exp_low);
            if (period != exp_period)
                report_mismatch(use_vs ? "VGA_VS period" : "VGA_HS period", period, exp_period);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before)
        begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
        else
            $display("test %s: ok", name);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        if (led != 4'h0)
            report_mismatch("LED", led, 0);
        if (vga_hs !== 1'b1)
            report_mismatch("VGA_HS", vga_hs, 1);
        if (vga_vs !== 1'b1)
            report_mismatch("VGA_VS", vga_vs, 1);
        if ({vga_r, vga_g, vga_b} != 12'h000)
            report_mismatch("VGA_RGB", {vga_r, vga_g, vga_b}, 0);
        finish_test("reset", e0);
    endtask

    task automatic test_counter();
        int e0;
        e0 = errors;
        follow_changes(20, 1'b0, 1'b0);
        finish_test("counter", e0);
    endtask

    task automatic test_run_dir();
        int         e0;
        logic [3:0] held;
        e0 = errors;
        press_key(0);                        // pause
        held = led;
        for (int n = 0; n < 100; n++)
        begin
            step_cycle();
            if (led != held)
            begin
                report_mismatch("LED", led, held);
                break;
            end
        end
        press_key(0);                        // run again
        press_key(1);                        // count down
        follow_changes(6, 1'b0, 1'b1);
        finish_test("run_dir", e0);
    endtask

    task automatic test_mode();
        int e0;
        e0 = errors;
        press_key(0);
        press_key(2);                        // paused so the walking bit stays put
        if (led != 4'b0001)
            report_mismatch("LED", led, 4'b0001);
        press_key(0);
        follow_changes(5, 1'b1, 1'b1);       // still counting down so the bit rotates right
        press_key(1);
        follow_changes(5, 1'b1, 1'b0);
        press_key(0);
        press_key(2);
        if (led != 4'b0000)
            report_mismatch("LED", led, 0);
        press_key(0);
        finish_test("mode", e0);
    endtask

    task automatic test_stripes();
        int         e0;
        bit         ok;
        logic [3:0] held;
        logic [2:0] idx;
        e0 = errors;
        follow_changes(3, 1'b0, 1'b0);
        press_key(0);                        // freeze the pattern
        held = led;
        wait_sync_edge(1'b1, 1'b1, 430000, ok);
        // skip the vertical blanking lines so the next line is visible
        for (int i = 0; i < 34 && ok; i++)
            wait_sync_edge(1'b0, 1'b1, 1000, ok);
        if (ok)
        begin
            for (int k = 0; k < 8; k++)
            begin
                repeat ((k == 0) ? 88 : 80) step_cycle();
                idx = 3'(k) ^ held[2:0];
                if (vga_r != (idx[2] ? 4'hf : 4'h0))
                    report_mismatch("VGA_R", vga_r, idx[2] ? 4'hf : 4'h0);
                if (vga_g != (idx[1] ? 4'hf : 4'h0))
                    report_mismatch("VGA_G", vga_g, idx[1] ? 4'hf : 4'h0);
                if (vga_b != (idx[0] ? 4'hf : 4'h0))
                    report_mismatch("VGA_B", vga_b, idx[0] ? 4'hf : 4'h0);
            end
        end
        if (led != held)
            report_mismatch("LED", led, held);
        finish_test("stripes", e0);
    endtask

    task automatic test_sync();
        int e0;
        e0 = errors;
        measure_sync(1'b0, 96, 800, 2000);
        measure_sync(1'b1, 1600, 420000, 430000);
        finish_test("sync", e0);
    endtask

    initial
    begin
        clk          = 1'b0;
        key          = 4'b1000;              // reset key held
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) step_cycle();
        key[3] = 1'b0;
        step_cycle();

        test_reset();
        test_counter();
        test_run_dir();
        test_mode();
        test_stripes();
        test_sync();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: list.f
logic/board_pkg.sv
logic/video_pkg.sv
logic/vga_if.sv
logic/slow_clk_gen.sv
logic/key_debouncer.sv
logic/led_pattern.sv
logic/vga_timing.sv
logic/vga_stripes.sv
logic/lab_top.sv
logic/board_specific_top.sv
tests/board_sva.sv
tests/tb_board.sv

// File: run.sh
#!/bin/sh
# build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board -f list.f -Mdir obj_dir -o sim_tb_board
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_board > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
